// ==== logic/csr_addr_pkg.sv ====
`default_nettype none

package csr_addr_pkg;

    localparam int CSR_ADDR_W = 14;

    // mode group
    localparam logic [CSR_ADDR_W-1:0] CSR_CRMD   = 14'h0;
    localparam logic [CSR_ADDR_W-1:0] CSR_PRMD   = 14'h1;
    localparam logic [CSR_ADDR_W-1:0] CSR_ECTL   = 14'h4;
    localparam logic [CSR_ADDR_W-1:0] CSR_ESTAT  = 14'h5;
    localparam logic [CSR_ADDR_W-1:0] CSR_ERA    = 14'h6;
    localparam logic [CSR_ADDR_W-1:0] CSR_EENTRY = 14'hc;

    // save group, registers follow SAVE0 back to back
    localparam logic [CSR_ADDR_W-1:0] CSR_SAVE0 = 14'h30;
    // address window reserved for save registers
    localparam int CSR_SAVE_SPAN = 16;

    // timer group
    localparam logic [CSR_ADDR_W-1:0] CSR_TID   = 14'h40;
    localparam logic [CSR_ADDR_W-1:0] CSR_TCFG  = 14'h41;
    localparam logic [CSR_ADDR_W-1:0] CSR_TVAL  = 14'h42;
    localparam logic [CSR_ADDR_W-1:0] CSR_CNTC  = 14'h43;
    localparam logic [CSR_ADDR_W-1:0] CSR_TICLR = 14'h44;

endpackage

`default_nettype wire

// ==== logic/csr_field_pkg.sv ====
`default_nettype none

package csr_field_pkg;

    localparam int CSR_DATA_W = 32;
    localparam int COUNT_W    = 64;

    // crmd
    localparam int PLV_LSB  = 0;
    localparam int PLV_W    = 2;
    localparam int IE_BIT   = 2;
    localparam int DA_BIT   = 3;
    localparam int PG_BIT   = 4;
    localparam int DATF_LSB = 5;
    localparam int DATM_LSB = 7;
    localparam int CRMD_W   = 9;
    localparam logic [CSR_DATA_W-1:0] CRMD_WMASK = (32'd3 << PLV_LSB) | (32'd1 << IE_BIT)
        | (32'd1 << DA_BIT) | (32'd1 << PG_BIT) | (32'd3 << DATF_LSB) | (32'd3 << DATM_LSB);
    localparam logic [CSR_DATA_W-1:0] CRMD_RESET = 32'd1 << DA_BIT;

    // prmd
    localparam int PPLV_LSB = 0;
    localparam int PIE_BIT  = 2;
    localparam int PRMD_W   = 3;
    localparam logic [CSR_DATA_W-1:0] PRMD_WMASK = (32'd3 << PPLV_LSB) | (32'd1 << PIE_BIT);

    // interrupt enable and pending layout
    localparam int LIE_W    = 13;
    localparam int SW_IRQ_W = 2;
    localparam int HW_IRQ_W = 9;
    localparam int TI_BIT   = 11;
    localparam logic [CSR_DATA_W-1:0] ECTL_WMASK  = (32'd1 << LIE_W) - 32'd1;
    localparam logic [CSR_DATA_W-1:0] ESTAT_WMASK = (32'd1 << SW_IRQ_W) - 32'd1;

    // exception cause
    localparam int ECODE_LSB    = 16;
    localparam int ECODE_W      = 6;
    localparam int ESUBCODE_LSB = 22;
    localparam int ESUBCODE_W   = 9;

    localparam int EENTRY_ALIGN = 6;
    localparam logic [CSR_DATA_W-1:0] EENTRY_WMASK = ~((32'd1 << EENTRY_ALIGN) - 32'd1);

    // tcfg and ticlr
    localparam int TCFG_EN       = 0;
    localparam int TCFG_PERIODIC = 1;
    localparam int INITVAL_LSB   = 2;
    localparam int TICLR_CLR     = 0;

endpackage

`default_nettype wire

// ==== logic/csr_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// write bus and read address from the arbiter to one register block
interface csr_bus_if
    import csr_addr_pkg::*, csr_field_pkg::*;
();

    logic                  we;
    logic [CSR_ADDR_W-1:0] waddr;
    logic [CSR_DATA_W-1:0] wdata;
    logic [CSR_ADDR_W-1:0] raddr;
    logic [CSR_DATA_W-1:0] rdata;

    modport arbiter (output we, output waddr, output wdata, output raddr, input rdata);

    modport block (input we, input waddr, input wdata, input raddr, output rdata);

endinterface

`default_nettype wire

// ==== logic/csr_write_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_write_arbiter
    import csr_addr_pkg::*, csr_field_pkg::*;
(
    input  logic                  wr1_en_i,
    input  logic [CSR_ADDR_W-1:0] wr1_addr_i,
    input  logic [CSR_DATA_W-1:0] wr1_data_i,
    input  logic                  wr2_en_i,
    input  logic [CSR_ADDR_W-1:0] wr2_addr_i,
    input  logic [CSR_DATA_W-1:0] wr2_data_i,
    input  logic [CSR_ADDR_W-1:0] rd_addr_i,
    output logic [CSR_DATA_W-1:0] rd_data_o,
    csr_bus_if.arbiter            bus_mode,
    csr_bus_if.arbiter            bus_timer,
    csr_bus_if.arbiter            bus_save
);

    logic                  we;
    logic [CSR_ADDR_W-1:0] waddr;
    logic [CSR_DATA_W-1:0] wdata;

    // port 1 wins, a colliding port 2 write is dropped
    assign we    = wr1_en_i | wr2_en_i;
    assign waddr = wr1_en_i ? wr1_addr_i : wr2_addr_i;
    assign wdata = wr1_en_i ? wr1_data_i : wr2_data_i;

    assign bus_mode.we     = we;
    assign bus_mode.waddr  = waddr;
    assign bus_mode.wdata  = wdata;
    assign bus_mode.raddr  = rd_addr_i;
    assign bus_timer.we    = we;
    assign bus_timer.waddr = waddr;
    assign bus_timer.wdata = wdata;
    assign bus_timer.raddr = rd_addr_i;
    assign bus_save.we     = we;
    assign bus_save.waddr  = waddr;
    assign bus_save.wdata  = wdata;
    assign bus_save.raddr  = rd_addr_i;

    // blocks return zero outside their own group
    assign rd_data_o = bus_mode.rdata | bus_timer.rdata | bus_save.rdata;

endmodule

`default_nettype wire

// ==== logic/csr_mode_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_mode_regs
    import csr_addr_pkg::*, csr_field_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    csr_bus_if.block              bus,
    input  logic                  excp_flush_i,
    input  logic [CSR_DATA_W-1:0] era_i,
    input  logic [ECODE_W-1:0]    ecode_i,
    input  logic [ESUBCODE_W-1:0] esubcode_i,
    input  logic                  ertn_flush_i,
    input  logic [HW_IRQ_W-1:0]   hw_irq_i,
    input  logic                  timer_irq_i,
    output logic                  has_int_o,
    output logic [CSR_DATA_W-1:0] eentry_o,
    output logic [CSR_DATA_W-1:0] era_o,
    output logic [PLV_W-1:0]      plv_o
);

    logic [CRMD_W-1:0]                crmd_q;
    logic [PRMD_W-1:0]                prmd_q;
    logic [LIE_W-1:0]                 lie_q;
    logic [SW_IRQ_W-1:0]              sw_irq_q;
    logic [HW_IRQ_W-1:0]              hw_irq_q;
    logic [ECODE_W-1:0]               ecode_q;
    logic [ESUBCODE_W-1:0]            esubcode_q;
    logic [CSR_DATA_W-1:0]            era_q;
    logic [CSR_DATA_W-EENTRY_ALIGN-1:0] eentry_q;
    logic [LIE_W-1:0]                 is_vec;
    logic [CSR_DATA_W-1:0]            estat_rd;
    logic                             crmd_wr;

    assign crmd_wr = bus.we && (bus.waddr == CSR_CRMD);

    // pending vector, bit 12 stays zero
    always_comb begin
        is_vec = '0;
        is_vec[SW_IRQ_W-1:0] = sw_irq_q;
        is_vec[SW_IRQ_W +: HW_IRQ_W] = hw_irq_q;
        is_vec[TI_BIT] = timer_irq_i;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            crmd_q <= CRMD_RESET[CRMD_W-1:0];
        end else if (excp_flush_i) begin
            crmd_q[PLV_LSB +: PLV_W] <= '0;
            crmd_q[IE_BIT] <= 1'b0;
        end else if (ertn_flush_i) begin
            crmd_q[PLV_LSB +: PLV_W] <= prmd_q[PPLV_LSB +: PLV_W];
            crmd_q[IE_BIT] <= prmd_q[PIE_BIT];
        end else if (crmd_wr) begin
            crmd_q <= bus.wdata[CRMD_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prmd_q <= '0;
        end else if (excp_flush_i) begin
            prmd_q[PPLV_LSB +: PLV_W] <= crmd_q[PLV_LSB +: PLV_W];
            prmd_q[PIE_BIT] <= crmd_q[IE_BIT];
        end else if (bus.we && bus.waddr == CSR_PRMD) begin
            prmd_q <= bus.wdata[PRMD_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lie_q <= '0;
        end else if (bus.we && bus.waddr == CSR_ECTL) begin
            lie_q <= bus.wdata[LIE_W-1:0];
        end
    end

    // estat, hw lines are sampled every cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            sw_irq_q   <= '0;
            hw_irq_q   <= '0;
            ecode_q    <= '0;
            esubcode_q <= '0;
        end else begin
            hw_irq_q <= hw_irq_i;
            if (excp_flush_i) begin
                ecode_q    <= ecode_i;
                esubcode_q <= esubcode_i;
            end else if (bus.we && bus.waddr == CSR_ESTAT) begin
                sw_irq_q <= bus.wdata[SW_IRQ_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (excp_flush_i) begin
            era_q <= era_i;
        end else if (bus.we && bus.waddr == CSR_ERA) begin
            era_q <= bus.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            eentry_q <= '0;
        end else if (bus.we && bus.waddr == CSR_EENTRY) begin
            eentry_q <= bus.wdata[CSR_DATA_W-1:EENTRY_ALIGN];
        end
    end

    always_comb begin
        estat_rd = '0;
        estat_rd[LIE_W-1:0] = is_vec;
        estat_rd[ECODE_LSB +: ECODE_W] = ecode_q;
        estat_rd[ESUBCODE_LSB +: ESUBCODE_W] = esubcode_q;
    end

    always_comb begin
        case (bus.raddr)
            CSR_CRMD:   bus.rdata = CSR_DATA_W'(crmd_q);
            CSR_PRMD:   bus.rdata = CSR_DATA_W'(prmd_q);
            CSR_ECTL:   bus.rdata = CSR_DATA_W'(lie_q);
            CSR_ESTAT:  bus.rdata = estat_rd;
            CSR_ERA:    bus.rdata = era_q;
            CSR_EENTRY: bus.rdata = eentry_o;
            default:    bus.rdata = '0;
        endcase
    end

    // forwarded level, flushes take priority over a crmd write
    always_comb begin
        if (excp_flush_i) begin
            plv_o = '0;
        end else if (ertn_flush_i) begin
            plv_o = prmd_q[PPLV_LSB +: PLV_W];
        end else if (crmd_wr) begin
            plv_o = bus.wdata[PLV_LSB +: PLV_W];
        end else begin
            plv_o = crmd_q[PLV_LSB +: PLV_W];
        end
    end

    assign has_int_o = (|(lie_q & is_vec)) & crmd_q[IE_BIT];
    assign eentry_o  = {eentry_q, {EENTRY_ALIGN{1'b0}}};
    assign era_o     = era_q;

endmodule

`default_nettype wire

// ==== logic/csr_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_timer
    import csr_addr_pkg::*, csr_field_pkg::*;
#(
    parameter logic [CSR_DATA_W-1:0] TIMER_ID_RESET = '0
) (
    input  logic                  clk,
    input  logic                  rst,
    csr_bus_if.block              bus,
    output logic                  timer_irq_o,
    output logic [COUNT_W-1:0]    timer_64_o,
    output logic [CSR_DATA_W-1:0] tid_o
);

    logic [CSR_DATA_W-1:0] tid_q;
    logic [CSR_DATA_W-1:0] tcfg_q;
    logic [CSR_DATA_W-1:0] tval_q;
    logic [CSR_DATA_W-1:0] cntc_q;
    logic [COUNT_W-1:0]    count_q;
    logic                  timer_en_q;
    logic                  pending_q;
    logic                  tcfg_wr;
    logic                  expire;

    assign tcfg_wr = bus.we && (bus.waddr == CSR_TCFG);
    assign expire  = timer_en_q && (tval_q == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            tid_q  <= TIMER_ID_RESET;
            tcfg_q <= '0;
            cntc_q <= '0;
        end else if (bus.we) begin
            if (bus.waddr == CSR_TID) tid_q <= bus.wdata;
            if (tcfg_wr) tcfg_q <= bus.wdata;
            if (bus.waddr == CSR_CNTC) cntc_q <= bus.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            timer_en_q <= 1'b0;
            pending_q  <= 1'b0;
        end else begin
            if (tcfg_wr) begin
                timer_en_q <= bus.wdata[TCFG_EN];
            end else if (expire) begin
                timer_en_q <= tcfg_q[TCFG_PERIODIC];
            end
            // clear wins over a same-cycle expiry
            if (bus.we && bus.waddr == CSR_TICLR && bus.wdata[TICLR_CLR]) begin
                pending_q <= 1'b0;
            end else if (expire) begin
                pending_q <= 1'b1;
            end
        end
    end

    // countdown, initval is in units of four cycles
    always_ff @(posedge clk) begin
        if (tcfg_wr) begin
            tval_q <= {bus.wdata[CSR_DATA_W-1:INITVAL_LSB], {INITVAL_LSB{1'b0}}};
        end else if (timer_en_q) begin
            if (tval_q != '0) begin
                tval_q <= tval_q - 1'b1;
            end else if (tcfg_q[TCFG_PERIODIC]) begin
                tval_q <= {tcfg_q[CSR_DATA_W-1:INITVAL_LSB], {INITVAL_LSB{1'b0}}};
            end else begin
                tval_q <= '1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + 1'b1;
        end
    end

    always_comb begin
        case (bus.raddr)
            CSR_TID:  bus.rdata = tid_q;
            CSR_TCFG: bus.rdata = tcfg_q;
            CSR_TVAL: bus.rdata = tval_q;
            CSR_CNTC: bus.rdata = cntc_q;
            default:  bus.rdata = '0;
        endcase
    end

    assign timer_irq_o = pending_q;
    assign timer_64_o  = count_q + {{(COUNT_W-CSR_DATA_W){cntc_q[CSR_DATA_W-1]}}, cntc_q};
    assign tid_o       = tid_q;

endmodule

`default_nettype wire

// ==== logic/csr_save_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_save_regs
    import csr_addr_pkg::*, csr_field_pkg::*;
#(
    parameter int NUM_SAVE = 4
) (
    input  logic     clk,
    csr_bus_if.block bus
);

    logic [CSR_DATA_W-1:0] save_q [NUM_SAVE];

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_SAVE; i++) begin
            if (bus.we && bus.waddr == CSR_ADDR_W'(CSR_SAVE0 + i)) begin
                save_q[i] <= bus.wdata;
            end
        end
    end

    // zero outside SAVE0 .. SAVE0+NUM_SAVE-1
    always_comb begin
        bus.rdata = '0;
        for (int i = 0; i < NUM_SAVE; i++) begin
            if (bus.raddr == CSR_ADDR_W'(CSR_SAVE0 + i)) begin
                bus.rdata = save_q[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/csr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_file
    import csr_addr_pkg::*, csr_field_pkg::*;
#(
    parameter int                    NUM_SAVE       = 4,
    parameter logic [CSR_DATA_W-1:0] TIMER_ID_RESET = '0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr1_en_i,
    input  logic [CSR_ADDR_W-1:0] wr1_addr_i,
    input  logic [CSR_DATA_W-1:0] wr1_data_i,
    input  logic                  wr2_en_i,
    input  logic [CSR_ADDR_W-1:0] wr2_addr_i,
    input  logic [CSR_DATA_W-1:0] wr2_data_i,
    input  logic [CSR_ADDR_W-1:0] rd_addr_i,
    output logic [CSR_DATA_W-1:0] rd_data_o,
    input  logic                  excp_flush_i,
    input  logic [CSR_DATA_W-1:0] era_i,
    input  logic [ECODE_W-1:0]    ecode_i,
    input  logic [ESUBCODE_W-1:0] esubcode_i,
    input  logic                  ertn_flush_i,
    input  logic [HW_IRQ_W-1:0]   hw_irq_i,
    output logic                  has_int_o,
    output logic [CSR_DATA_W-1:0] eentry_o,
    output logic [CSR_DATA_W-1:0] era_o,
    output logic [PLV_W-1:0]      plv_o,
    output logic [COUNT_W-1:0]    timer_64_o,
    output logic [CSR_DATA_W-1:0] tid_o
);

    logic timer_irq;

    csr_bus_if bus_mode ();
    csr_bus_if bus_timer ();
    csr_bus_if bus_save ();

    csr_write_arbiter u_arbiter (
        .wr1_en_i   (wr1_en_i),
        .wr1_addr_i (wr1_addr_i),
        .wr1_data_i (wr1_data_i),
        .wr2_en_i   (wr2_en_i),
        .wr2_addr_i (wr2_addr_i),
        .wr2_data_i (wr2_data_i),
        .rd_addr_i  (rd_addr_i),
        .rd_data_o  (rd_data_o),
        .bus_mode   (bus_mode.arbiter),
        .bus_timer  (bus_timer.arbiter),
        .bus_save   (bus_save.arbiter)
    );

    csr_mode_regs u_mode (
        .clk          (clk),
        .rst          (rst),
        .bus          (bus_mode.block),
        .excp_flush_i (excp_flush_i),
        .era_i        (era_i),
        .ecode_i      (ecode_i),
        .esubcode_i   (esubcode_i),
        .ertn_flush_i (ertn_flush_i),
        .hw_irq_i     (hw_irq_i),
        .timer_irq_i  (timer_irq),
        .has_int_o    (has_int_o),
        .eentry_o     (eentry_o),
        .era_o        (era_o),
        .plv_o        (plv_o)
    );

    csr_timer #(
        .TIMER_ID_RESET (TIMER_ID_RESET)
    ) u_timer (
        .clk         (clk),
        .rst         (rst),
        .bus         (bus_timer.block),
        .timer_irq_o (timer_irq),
        .timer_64_o  (timer_64_o),
        .tid_o       (tid_o)
    );

    csr_save_regs #(
        .NUM_SAVE (NUM_SAVE)
    ) u_save (
        .clk (clk),
        .bus (bus_save.block)
    );

endmodule

`default_nettype wire

// ==== include/csr_ref_model.svh ====
`ifndef CSR_REF_MODEL_SVH
`define CSR_REF_MODEL_SVH

// expects csr_addr_pkg and csr_field_pkg in scope

// bits that software writes keep
function automatic logic [31:0] writable_bits(input logic [13:0] addr);
    if (addr >= CSR_SAVE0 && addr < CSR_SAVE0 + CSR_SAVE_SPAN) begin
        return '1;
    end
    case (addr)
        CSR_CRMD:   return CRMD_WMASK;
        CSR_PRMD:   return PRMD_WMASK;
        CSR_ECTL:   return ECTL_WMASK;
        CSR_ESTAT:  return ESTAT_WMASK;
        CSR_EENTRY: return EENTRY_WMASK;
        CSR_ERA, CSR_TID, CSR_TCFG, CSR_CNTC: return '1;
        default:    return '0;
    endcase
endfunction

function automatic logic [31:0] reset_value(input logic [13:0] addr);
    if (addr == CSR_CRMD) begin
        return CRMD_RESET;
    end
    return '0;
endfunction

// value a read should return, given the last software write
function automatic logic [31:0] read_value(input logic [13:0] addr,
                                           input logic [31:0] shadow,
                                           input logic        written);
    if (!written) begin
        return reset_value(addr);
    end
    return shadow & writable_bits(addr);
endfunction

function automatic logic irq_level(input logic [LIE_W-1:0] lie,
                                   input logic [LIE_W-1:0] pending,
                                   input logic             ie);
    return (|(lie & pending)) && ie;
endfunction

`endif

// ==== testbench/tb_csr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_csr_file
    import csr_addr_pkg::*, csr_field_pkg::*;
;

    `include "csr_ref_model.svh"

    localparam int TIMER_TIMEOUT = 200;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  wr1_en_i;
    logic [CSR_ADDR_W-1:0] wr1_addr_i;
    logic [CSR_DATA_W-1:0] wr1_data_i;
    logic                  wr2_en_i;
    logic [CSR_ADDR_W-1:0] wr2_addr_i;
    logic [CSR_DATA_W-1:0] wr2_data_i;
    logic [CSR_ADDR_W-1:0] rd_addr_i;
    logic [CSR_DATA_W-1:0] rd_data_o;
    logic                  excp_flush_i;
    logic [CSR_DATA_W-1:0] era_i;
    logic [ECODE_W-1:0]    ecode_i;
    logic [ESUBCODE_W-1:0] esubcode_i;
    logic                  ertn_flush_i;
    logic [HW_IRQ_W-1:0]   hw_irq_i;
    logic                  has_int_o;
    logic [CSR_DATA_W-1:0] eentry_o;
    logic [CSR_DATA_W-1:0] era_o;
    logic [PLV_W-1:0]      plv_o;
    logic [COUNT_W-1:0]    timer_64_o;
    logic [CSR_DATA_W-1:0] tid_o;

    // shadow of software writes, indexed by the low address bits
    logic [CSR_DATA_W-1:0] shadow [0:127];
    logic                  written [0:127];
    logic [CSR_DATA_W-1:0] estat_cause;

    // requests to the comparing process
    logic                  chk_rd;
    logic                  chk_int;
    logic                  chk_plv;
    logic [CSR_DATA_W-1:0] exp_rd;
    logic                  exp_int;
    logic [PLV_W-1:0]      exp_plv;
    string                 chk_name;

    // cycles since reset release
    logic [COUNT_W-1:0]    cycle_count;

    integer seed;
    int     err_count;
    int     check_count;

    csr_file #(
        .NUM_SAVE (4)
    ) u_dut (
        .clk          (clk),
        .rst          (rst),
        .wr1_en_i     (wr1_en_i),
        .wr1_addr_i   (wr1_addr_i),
        .wr1_data_i   (wr1_data_i),
        .wr2_en_i     (wr2_en_i),
        .wr2_addr_i   (wr2_addr_i),
        .wr2_data_i   (wr2_data_i),
        .rd_addr_i    (rd_addr_i),
        .rd_data_o    (rd_data_o),
        .excp_flush_i (excp_flush_i),
        .era_i        (era_i),
        .ecode_i      (ecode_i),
        .esubcode_i   (esubcode_i),
        .ertn_flush_i (ertn_flush_i),
        .hw_irq_i     (hw_irq_i),
        .has_int_o    (has_int_o),
        .eentry_o     (eentry_o),
        .era_o        (era_o),
        .plv_o        (plv_o),
        .timer_64_o   (timer_64_o),
        .tid_o        (tid_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        if (rst) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

    // outputs are settled by the falling edge
    always @(negedge clk) begin : compare_outputs
        logic [CSR_DATA_W-1:0] exp_word;
        logic [COUNT_W-1:0]    exp_count;

        if (chk_rd) begin
            check_count++;
            assert (rd_data_o === exp_rd) else begin
                err_count++;
                $display("ERROR %s: expected %h, actual %h", chk_name, exp_rd, rd_data_o);
            end
        end
        if (chk_int) begin
            check_count++;
            assert (has_int_o === exp_int) else begin
                err_count++;
                $display("ERROR %s: expected %b, actual %b", chk_name, exp_int, has_int_o);
            end
        end
        if (chk_plv) begin
            check_count++;
            assert (plv_o === exp_plv) else begin
                err_count++;
                $display("ERROR %s: expected %h, actual %h", chk_name, exp_plv, plv_o);
            end
        end
        // register outputs, every cycle out of reset
        if (!rst) begin
            exp_word = read_value(CSR_EENTRY, shadow[CSR_EENTRY], written[CSR_EENTRY]);
            check_count++;
            assert (eentry_o === exp_word) else begin
                err_count++;
                $display("ERROR eentry_o: expected %h, actual %h", exp_word, eentry_o);
            end
            exp_word = read_value(CSR_TID, shadow[CSR_TID], written[CSR_TID]);
            check_count++;
            assert (tid_o === exp_word) else begin
                err_count++;
                $display("ERROR tid_o: expected %h, actual %h", exp_word, tid_o);
            end
            // era has no reset value
            if (written[CSR_ERA]) begin
                exp_word = read_value(CSR_ERA, shadow[CSR_ERA], 1'b1);
                check_count++;
                assert (era_o === exp_word) else begin
                    err_count++;
                    $display("ERROR era_o: expected %h, actual %h", exp_word, era_o);
                end
            end
            exp_word  = read_value(CSR_CNTC, shadow[CSR_CNTC], written[CSR_CNTC]);
            exp_count = cycle_count + COUNT_W'($signed(exp_word));
            check_count++;
            assert (timer_64_o === exp_count) else begin
                err_count++;
                $display("ERROR timer_64_o: expected %h, actual %h", exp_count, timer_64_o);
            end
        end
    end

    task automatic write_csr(input int port, input logic [CSR_ADDR_W-1:0] addr,
                             input logic [CSR_DATA_W-1:0] data);
        @(posedge clk);
        if (port == 1) begin
            wr1_en_i   <= 1'b1;
            wr1_addr_i <= addr;
            wr1_data_i <= data;
        end else begin
            wr2_en_i   <= 1'b1;
            wr2_addr_i <= addr;
            wr2_data_i <= data;
        end
        // plv is forwarded in the write cycle
        if (addr == CSR_CRMD) begin
            chk_plv  <= 1'b1;
            exp_plv  <= data[PLV_LSB +: PLV_W];
            chk_name <= "crmd_plv_forward";
        end
        @(posedge clk);
        wr1_en_i <= 1'b0;
        wr2_en_i <= 1'b0;
        chk_plv  <= 1'b0;
        shadow[addr[6:0]]  = data;
        written[addr[6:0]] = 1'b1;
    endtask

    // port 2 loses and its write is gone
    task automatic collide_writes(input logic [CSR_ADDR_W-1:0] addr1,
                                  input logic [CSR_DATA_W-1:0] data1,
                                  input logic [CSR_ADDR_W-1:0] addr2,
                                  input logic [CSR_DATA_W-1:0] data2);
        @(posedge clk);
        wr1_en_i   <= 1'b1;
        wr1_addr_i <= addr1;
        wr1_data_i <= data1;
        wr2_en_i   <= 1'b1;
        wr2_addr_i <= addr2;
        wr2_data_i <= data2;
        @(posedge clk);
        wr1_en_i <= 1'b0;
        wr2_en_i <= 1'b0;
        shadow[addr1[6:0]]  = data1;
        written[addr1[6:0]] = 1'b1;
    endtask

    task automatic expect_value(input string name, input logic [CSR_ADDR_W-1:0] addr,
                                input logic [CSR_DATA_W-1:0] value);
        @(posedge clk);
        rd_addr_i <= addr;
        exp_rd    <= value;
        chk_name  <= name;
        chk_rd    <= 1'b1;
        @(posedge clk);
        chk_rd <= 1'b0;
    endtask

    task automatic read_back(input string name, input logic [CSR_ADDR_W-1:0] addr);
        expect_value(name, addr, read_value(addr, shadow[addr[6:0]], written[addr[6:0]]));
    endtask

    task automatic expect_irq(input string name, input logic [LIE_W-1:0] pending);
        @(posedge clk);
        exp_int  <= irq_level(shadow[CSR_ECTL][LIE_W-1:0], pending,
                              shadow[CSR_CRMD][IE_BIT] & written[CSR_CRMD]);
        chk_name <= name;
        chk_int  <= 1'b1;
        @(posedge clk);
        chk_int <= 1'b0;
    endtask

    initial begin
        logic [CSR_DATA_W-1:0] data_a;
        logic [CSR_DATA_W-1:0] data_b;
        logic [PLV_W-1:0]      old_plv;
        logic                  old_ie;
        logic [CSR_DATA_W-1:0] era_v;
        logic [ECODE_W-1:0]    ecode_v;
        logic [ESUBCODE_W-1:0] esub_v;
        logic                  got;
        int                    initval;
        int                    k;

        seed        = 32'h0ffc_dda3;
        err_count   = 0;
        check_count = 0;
        estat_cause = '0;
        for (int a = 0; a < 128; a++) begin
            shadow[a]  = '0;
            written[a] = 1'b0;
        end
        rst          <= 1'b1;
        wr1_en_i     <= 1'b0;
        wr1_addr_i   <= '0;
        wr1_data_i   <= '0;
        wr2_en_i     <= 1'b0;
        wr2_addr_i   <= '0;
        wr2_data_i   <= '0;
        rd_addr_i    <= '0;
        excp_flush_i <= 1'b0;
        era_i        <= '0;
        ecode_i      <= '0;
        esubcode_i   <= '0;
        ertn_flush_i <= 1'b0;
        hw_irq_i     <= '0;
        chk_rd       <= 1'b0;
        chk_int      <= 1'b0;
        chk_plv      <= 1'b0;
        exp_rd       <= '0;
        exp_int      <= 1'b0;
        exp_plv      <= '0;
        chk_name     <= "";
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        read_back("reset_crmd", CSR_CRMD);
        expect_irq("reset_irq", '0);

        // save registers, ports alternate
        for (int i = 0; i < 4; i++) begin
            data_a = $random(seed);
            write_csr((i % 2 == 0) ? 1 : 2, CSR_ADDR_W'(CSR_SAVE0 + i), data_a);
        end
        for (int i = 0; i < 4; i++) begin
            read_back($sformatf("save%0d", i), CSR_ADDR_W'(CSR_SAVE0 + i));
        end

        data_a = $random(seed);
        data_b = $random(seed);
        collide_writes(CSR_ADDR_W'(CSR_SAVE0 + 2), data_a, CSR_ADDR_W'(CSR_SAVE0 + 3), data_b);
        read_back("collide_port1", CSR_ADDR_W'(CSR_SAVE0 + 2));
        read_back("collide_port2", CSR_ADDR_W'(CSR_SAVE0 + 3));

        data_a = $random(seed);
        write_csr(1, CSR_CRMD, data_a);
        read_back("crmd_mask", CSR_CRMD);

        // exception entry from plv 3 with interrupts on
        write_csr(1, CSR_CRMD, CRMD_RESET | 32'd3 | (32'd1 << IE_BIT));
        old_plv = shadow[CSR_CRMD][PLV_LSB +: PLV_W];
        old_ie  = shadow[CSR_CRMD][IE_BIT];
        era_v   = $random(seed);
        ecode_v = $random(seed);
        esub_v  = $random(seed);
        @(posedge clk);
        excp_flush_i <= 1'b1;
        era_i        <= era_v;
        ecode_i      <= ecode_v;
        esubcode_i   <= esub_v;
        chk_plv      <= 1'b1;
        exp_plv      <= '0;
        chk_name     <= "excp_plv";
        @(posedge clk);
        excp_flush_i <= 1'b0;
        chk_plv      <= 1'b0;
        shadow[CSR_ERA]  = era_v;
        written[CSR_ERA] = 1'b1;
        shadow[CSR_CRMD][PLV_LSB +: PLV_W] = '0;
        shadow[CSR_CRMD][IE_BIT]           = 1'b0;
        shadow[CSR_PRMD]  = (32'(old_ie) << PIE_BIT) | (32'(old_plv) << PPLV_LSB);
        written[CSR_PRMD] = 1'b1;
        estat_cause = (32'(ecode_v) << ECODE_LSB) | (32'(esub_v) << ESUBCODE_LSB);
        read_back("excp_era", CSR_ERA);
        read_back("excp_crmd", CSR_CRMD);
        read_back("excp_prmd", CSR_PRMD);
        expect_value("excp_estat", CSR_ESTAT,
                     read_value(CSR_ESTAT, shadow[CSR_ESTAT], written[CSR_ESTAT]) | estat_cause);

        @(posedge clk);
        ertn_flush_i <= 1'b1;
        chk_plv      <= 1'b1;
        exp_plv      <= old_plv;
        chk_name     <= "ertn_plv";
        @(posedge clk);
        ertn_flush_i <= 1'b0;
        chk_plv      <= 1'b0;
        shadow[CSR_CRMD][PLV_LSB +: PLV_W] = old_plv;
        shadow[CSR_CRMD][IE_BIT]           = old_ie;
        read_back("ertn_crmd", CSR_CRMD);

        // one-shot timer interrupt
        write_csr(1, CSR_ECTL, 32'd1 << TI_BIT);
        write_csr(1, CSR_CRMD, CRMD_RESET | (32'd1 << IE_BIT));
        initval = 1 + ($random(seed) & 3);
        write_csr(2, CSR_TCFG, (32'(initval) << INITVAL_LSB) | (32'd1 << TCFG_EN));
        got = 1'b0;
        for (int n = 0; n < TIMER_TIMEOUT && !got; n++) begin
            @(negedge clk);
            got = has_int_o;
        end
        assert (got) else begin
            err_count++;
            $display("timer interrupt did not rise within %0d cycles", TIMER_TIMEOUT);
        end
        expect_irq("timer_irq", LIE_W'(1) << TI_BIT);
        expect_value("timer_estat", CSR_ESTAT, estat_cause | (32'd1 << TI_BIT));
        write_csr(1, CSR_TICLR, 32'd1 << TICLR_CLR);
        expect_irq("timer_clear", '0);

        // one hardware line
        k = $unsigned($random(seed)) % HW_IRQ_W;
        write_csr(1, CSR_ECTL, 32'd1 << (SW_IRQ_W + k));
        @(posedge clk);
        hw_irq_i <= HW_IRQ_W'(1) << k;
        expect_irq("hw_irq", LIE_W'(1) << (SW_IRQ_W + k));
        expect_value("hw_estat", CSR_ESTAT, estat_cause | (32'd1 << (SW_IRQ_W + k)));
        write_csr(2, CSR_ECTL, '0);
        expect_irq("hw_irq_masked", LIE_W'(1) << (SW_IRQ_W + k));
        @(posedge clk);
        hw_irq_i <= '0;

        // entry address, timer id and a negative counter offset
        data_a = $random(seed);
        write_csr(2, CSR_EENTRY, data_a);
        read_back("eentry", CSR_EENTRY);
        data_a = $random(seed);
        write_csr(1, CSR_TID, data_a);
        read_back("tid", CSR_TID);
        data_a = $random(seed) | 32'h8000_0000;
        write_csr(1, CSR_CNTC, data_a);
        read_back("cntc", CSR_CNTC);
        repeat (2) @(posedge clk);

        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
logic/csr_addr_pkg.sv
logic/csr_field_pkg.sv
logic/csr_bus_if.sv
logic/csr_write_arbiter.sv
logic/csr_mode_regs.sv
logic/csr_timer.sv
logic/csr_save_regs.sv
logic/csr_file.sv
testbench/tb_csr_file.sv

// ==== Bender.yml ====
package:
  name: csr_file

sources:
  - files:
      - logic/csr_addr_pkg.sv
      - logic/csr_field_pkg.sv
      - logic/csr_bus_if.sv
      - logic/csr_write_arbiter.sv
      - logic/csr_mode_regs.sv
      - logic/csr_timer.sv
      - logic/csr_save_regs.sv
      - logic/csr_file.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_csr_file.sv
